/* logic/ioBridgePkg.sv */
// Shared widths, field positions, register addresses and enums for the IO bridge pager; import where needed

package ioBridgePkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////

   // Processor register word
   localparam int wordWidth = 36;
   // Device bridge address
   localparam int devAddrWidth = 18;
   // Virtual page number and table depth
   localparam int pageIndexWidth = 6;
   localparam int numPages = 64;
   // Physical side
   localparam int ppnWidth = 11;
   localparam int wordNumWidth = 9;
   localparam int physAddrWidth = 20;
   // RPW, E16, FTM, VLD
   localparam int flagWidth = 4;
   // Internal entry is flags then PPN
   localparam int entryWidth = 15;

   ////////////////////////////////////////
   // Processor register map
   ////////////////////////////////////////

   localparam int regAddrWidth = 7;
   // 0 to 63 are page entries
   localparam logic [regAddrWidth-1:0] statusRegAddr = 7'd64;

   // Word layouts, big-endian bit numbers
   localparam int wrFlagPos = 18;
   localparam int wrPpnPos = 25;
   localparam int rdFlagPos = 5;
   localparam int rdPpnPos = 16;

   // Internal entry layout
   localparam int entryRpw = 0;
   localparam int entryE16 = 1;
   localparam int entryFtm = 2;
   localparam int entryVld = 3;
   localparam int entryPpnPos = 4;

   // Device address fields, bit 0 at the top
   localparam int devA17Pos = 0;
   localparam int devPagePos = 1;
   localparam int devWordPos = 7;
   localparam int devWPos = 16;
   localparam int devBPos = 17;

   // Status register read layout
   localparam int statusFaultPos = 35;
   localparam int statusCausePos = 34;
   localparam int statusPagePos = 28;

   ////////////////////////////////////////
   // Enums
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      sIdle, sCpuRead, sCpuLoad, sCpuDone, sDevLookup, sDevResolve, sDevDone
   } bridgeState_t;

   typedef enum logic [1:0] {
      opNone, opCpuRead, opCpuWrite, opDevXlate
   } bridgeOp_t;

endpackage

/* logic/bridgeControl.sv */
// Bridge controller FSM; arbitrates processor and device handshakes and sequences datapath strobes
`timescale 1ns/100ps

module bridgeControl (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cpuReq,
   input  logic                   cpuWrite,
   input  logic                   devReq,
   output logic                   cpuAck,
   output logic                   devAck,
   output ioBridgePkg::bridgeOp_t op,
   output logic                   captureStb,
   output logic                   loadStb
);

   import ioBridgePkg::*;

   bridgeState_t state;
   bridgeState_t nextState;

   ////////////////////////////////////////
   // State register
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= sIdle;
      end
      else
      begin
         state <= nextState;
      end
   end

   // Three cycles from req to ack on either side
   always_comb
   begin
      nextState = state;
      unique case (state)
         sIdle:
         begin
            // Device has priority
            if (devReq)
            begin
               nextState = sDevLookup;
            end
            else if (cpuReq)
            begin
               nextState = sCpuRead;
            end
         end
         sCpuRead:    nextState = sCpuLoad;
         sCpuLoad:    nextState = sCpuDone;
         // Hold ack until the processor lets go
         sCpuDone:    nextState = cpuReq ? sCpuDone : sIdle;
         sDevLookup:  nextState = sDevResolve;
         sDevResolve: nextState = sDevDone;
         sDevDone:    nextState = devReq ? sDevDone : sIdle;
         default:     nextState = sIdle;
      endcase
   end

   ////////////////////////////////////////
   // Operation selector
   ////////////////////////////////////////

   // Picked when a request is accepted, held to the end of the handshake
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         op <= opNone;
      end
      else if (state == sIdle)
      begin
         if (devReq)
         begin
            op <= opDevXlate;
         end
         else if (cpuReq)
         begin
            op <= cpuWrite ? opCpuWrite : opCpuRead;
         end
         else
         begin
            op <= opNone;
         end
      end
      else if (nextState == sIdle)
      begin
         op <= opNone;
      end
   end

   // Strobes and acks straight from state
   assign captureStb = (state == sCpuRead) || (state == sDevLookup);
   assign loadStb    = (state == sCpuLoad) || (state == sDevResolve);
   assign cpuAck     = (state == sCpuDone);
   assign devAck     = (state == sDevDone);

   ////////////////////////////////////////
   // Handshake checks
   ////////////////////////////////////////

   // Ack must answer a live request
   cpuAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
      $rose(cpuAck) |-> cpuReq)
      else $error("cpuAck rose without cpuReq");

   devAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
      $rose(devAck) |-> devReq)
      else $error("devAck rose without devReq");

endmodule

/* logic/pageMap.sv */
// Dual-port 64x15 page table; processor read/write port with word packing, device read-only port
`timescale 1ns/100ps

module pageMap (
   input  logic                                 clk,
   input  ioBridgePkg::bridgeOp_t               op,
   input  logic                                 loadStb,
   input  logic [ioBridgePkg::regAddrWidth-1:0] regAddr,
   input  logic [0:ioBridgePkg::wordWidth-1]    regWData,
   input  logic [ioBridgePkg::pageIndexWidth-1:0] devPage,
   output logic [0:ioBridgePkg::wordWidth-1]    cpuEntryWord,
   output logic [0:ioBridgePkg::entryWidth-1]   devEntry
);

   import ioBridgePkg::*;

   // Table storage, flags then PPN
   logic [0:entryWidth-1] pageRam [0:numPages-1];

   logic [pageIndexWidth-1:0] cpuPage;
   logic                      tableSel;
   logic [0:entryWidth-1]     wrEntry;
   logic [0:entryWidth-1]     cpuEntry;

   ////////////////////////////////////////
   // Processor port
   ////////////////////////////////////////

   // Low address bits pick the entry
   assign cpuPage  = regAddr[pageIndexWidth-1:0];
   // Status register sits just above the table
   assign tableSel = (regAddr < statusRegAddr);

   // Write layout to internal entry
   // Bits 22 to 24 and the left half are ignored
   assign wrEntry = {regWData[wrFlagPos +: flagWidth], regWData[wrPpnPos +: ppnWidth]};

   always_ff @(posedge clk)
   begin
      if (loadStb && (op == opCpuWrite) && tableSel)
      begin
         pageRam[cpuPage] <= wrEntry;
      end
   end

   // Asynchronous read, so a write shows up the next cycle
   assign cpuEntry = pageRam[cpuPage];

   // Internal entry to read layout
   always_comb
   begin
      cpuEntryWord = '0;
      // Flags land at 5 to 8
      cpuEntryWord[rdFlagPos +: flagWidth] = cpuEntry[entryRpw +: flagWidth];
      // PPN straddles the halves, 16 to 26
      cpuEntryWord[rdPpnPos +: ppnWidth] = cpuEntry[entryPpnPos +: ppnWidth];
   end

   ////////////////////////////////////////
   // Device port
   ////////////////////////////////////////

   // Page comes registered from the translator
   // Entry valid the cycle after capture
   assign devEntry = pageRam[devPage];

endmodule

/* logic/addressTranslator.sv */
// Device address translation; captures the bridge address, forms physical address and flags, keeps fault status
`timescale 1ns/100ps

module addressTranslator (
   input  logic                                   clk,
   input  logic                                   rst,
   input  ioBridgePkg::bridgeOp_t                 op,
   input  logic                                   captureStb,
   input  logic                                   loadStb,
   input  logic [0:ioBridgePkg::devAddrWidth-1]   devAddr,
   input  logic [0:ioBridgePkg::entryWidth-1]     devEntry,
   input  logic [ioBridgePkg::regAddrWidth-1:0]   regAddr,
   output logic [ioBridgePkg::pageIndexWidth-1:0] devPage,
   output logic [0:ioBridgePkg::physAddrWidth-1]  memAddr,
   output logic [0:ioBridgePkg::flagWidth]        memFlags,
   output logic                                   pageFail,
   output logic [0:ioBridgePkg::wordWidth-1]      statusWord
);

   import ioBridgePkg::*;

   logic [0:devAddrWidth-1]   devAddrReg;
   logic                      overRange;
   logic                      notValid;
   logic                      xlateLoad;
   logic                      statusClear;
   logic                      statusFault;
   logic                      statusCause;
   logic [pageIndexWidth-1:0] statusPage;

   ////////////////////////////////////////
   // Address capture and lookup
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (captureStb && (op == opDevXlate))
      begin
         devAddrReg <= devAddr;
      end
   end

   assign devPage = devAddrReg[devPagePos +: pageIndexWidth];

   // Fault causes
   assign overRange = devAddrReg[devA17Pos];
   assign notValid  = !devEntry[entryVld];
   assign xlateLoad = loadStb && (op == opDevXlate);

   // PPN then word number; W and B pass through with the entry flags
   always_ff @(posedge clk)
   begin
      if (xlateLoad)
      begin
         memAddr  <= {devEntry[entryPpnPos +: ppnWidth], devAddrReg[devWordPos +: wordNumWidth]};
         memFlags <= {devEntry[entryRpw], devEntry[entryE16], devEntry[entryFtm],
                      devAddrReg[devWPos], devAddrReg[devBPos]};
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pageFail <= 1'b0;
      end
      else if (xlateLoad)
      begin
         pageFail <= overRange || notValid;
      end
   end

   ////////////////////////////////////////
   // Sticky fault status
   ////////////////////////////////////////

   // Any processor write to the status address clears it
   assign statusClear = loadStb && (op == opCpuWrite) && (regAddr == statusRegAddr);

   always_ff @(posedge clk)
   begin
      if (rst || statusClear)
      begin
         statusFault <= 1'b0;
         statusCause <= 1'b0;
         statusPage  <= '0;
      end
      else if (xlateLoad && (overRange || notValid) && !statusFault)
      begin
         // First fault wins
         statusFault <= 1'b1;
         statusCause <= overRange;
         statusPage  <= devPage;
      end
   end

   always_comb
   begin
      statusWord = '0;
      statusWord[statusFaultPos] = statusFault;
      statusWord[statusCausePos] = statusCause;
      statusWord[statusPagePos +: pageIndexWidth] = statusPage;
   end

endmodule

/* logic/cpuRegisterPort.sv */
// Processor register port; latches address and write data, returns page entry or status read data
`timescale 1ns/100ps

module cpuRegisterPort (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 captureStb,
   input  logic                                 loadStb,
   input  ioBridgePkg::bridgeOp_t               op,
   input  logic [ioBridgePkg::regAddrWidth-1:0] cpuAddr,
   input  logic [0:ioBridgePkg::wordWidth-1]    cpuWData,
   input  logic [0:ioBridgePkg::wordWidth-1]    cpuEntryWord,
   input  logic [0:ioBridgePkg::wordWidth-1]    statusWord,
   output logic [ioBridgePkg::regAddrWidth-1:0] regAddr,
   output logic [0:ioBridgePkg::wordWidth-1]    regWData,
   output logic [0:ioBridgePkg::wordWidth-1]    cpuRData
);

   import ioBridgePkg::*;

   logic                  cpuOp;
   logic [0:wordWidth-1]  readMux;

   assign cpuOp = (op == opCpuRead) || (op == opCpuWrite);

   ////////////////////////////////////////
   // Request capture
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (captureStb && cpuOp)
      begin
         regAddr  <= cpuAddr;
         regWData <= cpuWData;
      end
   end

   // Table, status, or nothing above the status register
   always_comb
   begin
      if (regAddr < statusRegAddr)
      begin
         readMux = cpuEntryWord;
      end
      else if (regAddr == statusRegAddr)
      begin
         readMux = statusWord;
      end
      else
      begin
         readMux = '0;
      end
   end

   // Read data held through ack
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cpuRData <= '0;
      end
      else if (loadStb && (op == opCpuRead))
      begin
         cpuRData <= readMux;
      end
   end

endmodule

/* logic/ioBridge.sv */
// IO bridge pager top level; connects the controller to the page table, translator and register port
`timescale 1ns/100ps

module ioBridge (
   input  logic                                   clk,
   input  logic                                   rst,
   // Processor handshake
   input  logic                                   cpuReq,
   input  logic                                   cpuWrite,
   input  logic [ioBridgePkg::regAddrWidth-1:0]   cpuAddr,
   input  logic [0:ioBridgePkg::wordWidth-1]      cpuWData,
   output logic                                   cpuAck,
   output logic [0:ioBridgePkg::wordWidth-1]      cpuRData,
   // Device handshake
   input  logic                                   devReq,
   input  logic [0:ioBridgePkg::devAddrWidth-1]   devAddr,
   output logic                                   devAck,
   output logic [0:ioBridgePkg::physAddrWidth-1]  memAddr,
   output logic [0:ioBridgePkg::flagWidth]        memFlags,
   output logic                                   pageFail
);

   import ioBridgePkg::*;

   bridgeOp_t                 op;
   logic                      captureStb;
   logic                      loadStb;
   logic [regAddrWidth-1:0]   regAddr;
   logic [0:wordWidth-1]      regWData;
   logic [0:wordWidth-1]      cpuEntryWord;
   logic [0:wordWidth-1]      statusWord;
   logic [0:entryWidth-1]     devEntry;
   logic [pageIndexWidth-1:0] devPage;

   bridgeControl control_i (.clk, .rst, .cpuReq, .cpuWrite, .devReq, .cpuAck, .devAck,
                            .op, .captureStb, .loadStb);

   pageMap pageMap_i (.clk, .op, .loadStb, .regAddr, .regWData, .devPage,
                      .cpuEntryWord, .devEntry);

   addressTranslator translator_i (.clk, .rst, .op, .captureStb, .loadStb, .devAddr,
                                   .devEntry, .regAddr, .devPage, .memAddr, .memFlags,
                                   .pageFail, .statusWord);

   cpuRegisterPort regPort_i (.clk, .rst, .captureStb, .loadStb, .op, .cpuAddr, .cpuWData,
                              .cpuEntryWord, .statusWord, .regAddr, .regWData, .cpuRData);

endmodule

/* verif/ioBridgeChecker.sv */
// Testbench checker for the IO bridge; watches both handshakes, compares against model values, keeps counts
`timescale 1ns/100ps

module ioBridgeChecker (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cpuReq,
   input  logic                                  cpuAck,
   input  logic [0:ioBridgePkg::wordWidth-1]     cpuRData,
   input  logic                                  devReq,
   input  logic                                  devAck,
   input  logic [0:ioBridgePkg::physAddrWidth-1] memAddr,
   input  logic [0:ioBridgePkg::flagWidth]       memFlags,
   input  logic                                  pageFail,
   input  int                                    testId,
   input  logic                                  testDone,
   input  logic                                  runDone,
   input  logic                                  cpuExpect,
   input  logic [0:ioBridgePkg::wordWidth-1]     expCpuRData,
   input  logic [0:ioBridgePkg::physAddrWidth-1] expMemAddr,
   input  logic [0:ioBridgePkg::flagWidth]       expMemFlags,
   input  logic                                  expPageFail,
   input  int                                    cpuIssued,
   input  int                                    devIssued,
   output int                                    failCount
);

   import ioBridgePkg::*;

   int   passCount;
   int   testChecks;
   int   testErrors;
   int   cpuDone;
   int   devDone;
   logic cpuAckLast;
   logic devAckLast;

   function automatic string testName(input int id);
      case (id)
         1:       return "entryRoundTrip";
         2:       return "validTranslation";
         3:       return "invalidPage";
         4:       return "overRange";
         5:       return "statusClear";
         6:       return "concurrentTraffic";
         default: return "noTest";
      endcase
   endfunction

   task automatic compareValue(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
      testChecks++;
      if (expected !== actual)
      begin
         testErrors++;
         failCount++;
         $display("[FAIL] %s %s expected %h actual %h", testName(testId), what, expected, actual);
      end
      else
      begin
         passCount++;
      end
   endtask

   task automatic protocolError(input string what);
      testErrors++;
      failCount++;
      $display("Error in %s: %s", testName(testId), what);
   endtask

   ////////////////////////////////////////
   // Sampling at the falling edge
   ////////////////////////////////////////

   // Outputs settle mid-cycle, expectations land right after the rising edge
   always @(negedge clk)
   begin
      if (rst)
      begin
         failCount  = 0;
         passCount  = 0;
         testChecks = 0;
         testErrors = 0;
         cpuDone    = 0;
         devDone    = 0;
      end
      else
      begin
         if (cpuAck && devAck)
         begin
            protocolError("cpuAck and devAck are high at the same time");
         end
         // Processor completion
         if (cpuAck && !cpuAckLast)
         begin
            cpuDone++;
            if (!cpuReq)
            begin
               protocolError("cpuAck rose while cpuReq was low");
            end
            if (cpuExpect)
            begin
               compareValue("cpuRData", 64'(expCpuRData), 64'(cpuRData));
            end
         end
         // Device completion
         if (devAck && !devAckLast)
         begin
            devDone++;
            if (!devReq)
            begin
               protocolError("devAck rose while devReq was low");
            end
            compareValue("pageFail", 64'(expPageFail), 64'(pageFail));
            // Address and flags only mean something on a good translation
            if (!expPageFail)
            begin
               compareValue("memAddr", 64'(expMemAddr), 64'(memAddr));
               compareValue("memFlags", 64'(expMemFlags), 64'(memFlags));
            end
         end
         if (testDone)
         begin
            $display("Test %0d %s finished: %0d checks, %0d errors", testId, testName(testId),
                     testChecks, testErrors);
            testChecks = 0;
            testErrors = 0;
         end
         if (runDone)
         begin
            // Each request completes exactly once
            if (cpuDone != cpuIssued)
            begin
               protocolError($sformatf("%0d processor requests issued but %0d acknowledged",
                                       cpuIssued, cpuDone));
            end
            if (devDone != devIssued)
            begin
               protocolError($sformatf("%0d device requests issued but %0d acknowledged",
                                       devIssued, devDone));
            end
            $display("Checks passed: %0d, checks failed: %0d", passCount, failCount);
         end
      end
      cpuAckLast = cpuAck;
      devAckLast = devAck;
   end

endmodule

/* verif/ioBridgeTb.sv */
// Testbench top for the IO bridge pager; drives LCG traffic on both handshakes and keeps the page-table model
`timescale 1ns/100ps

module ioBridgeTb;

   import ioBridgePkg::*;

   // Longest wait for any ack edge
   localparam int ackTimeout = 64;

   logic                     clk;
   logic                     rst;
   logic                     cpuReq;
   logic                     cpuWrite;
   logic [regAddrWidth-1:0]  cpuAddr;
   logic [0:wordWidth-1]     cpuWData;
   logic                     cpuAck;
   logic [0:wordWidth-1]     cpuRData;
   logic                     devReq;
   logic [0:devAddrWidth-1]  devAddr;
   logic                     devAck;
   logic [0:physAddrWidth-1] memAddr;
   logic [0:flagWidth]       memFlags;
   logic                     pageFail;

   // Checker side
   int                       testId;
   logic                     testDone;
   logic                     runDone;
   logic                     cpuExpect;
   logic [0:wordWidth-1]     expCpuRData;
   logic [0:physAddrWidth-1] expMemAddr;
   logic [0:flagWidth]       expMemFlags;
   logic                     expPageFail;
   int                       cpuIssued;
   int                       devIssued;
   int                       failCount;

   // Model: flags are RPW, E16, FTM, VLD from left
   logic [0:flagWidth-1]      modelFlags [numPages];
   logic [0:ppnWidth-1]       modelPpn [numPages];
   logic                      statusFault;
   logic                      statusCause;
   logic [pageIndexWidth-1:0] statusPage;
   logic [31:0]               seed;

   ioBridge dut_i (.clk, .rst, .cpuReq, .cpuWrite, .cpuAddr, .cpuWData, .cpuAck, .cpuRData,
                   .devReq, .devAddr, .devAck, .memAddr, .memFlags, .pageFail);

   ioBridgeChecker checker_i (.clk, .rst, .cpuReq, .cpuAck, .cpuRData, .devReq, .devAck,
                              .memAddr, .memFlags, .pageFail, .testId, .testDone, .runDone,
                              .cpuExpect, .expCpuRData, .expMemAddr, .expMemFlags,
                              .expPageFail, .cpuIssued, .devIssued, .failCount);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // Random numbers
   ////////////////////////////////////////

   function automatic logic [31:0] nextRandom();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [0:wordWidth-1] randomWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = nextRandom();
      lo = nextRandom();
      return {hi[31:28], lo};
   endfunction

   function automatic logic [pageIndexWidth-1:0] randomPage();
      logic [31:0] r;
      r = nextRandom();
      return r[29:24];
   endfunction

   function automatic logic chance(input int percent);
      logic [31:0] r;
      r = nextRandom();
      return (int'(r[31:16]) % 100) < percent;
   endfunction

   // 0 to 3 cycles
   function automatic int fewCycles();
      logic [31:0] r;
      r = nextRandom();
      return int'(r[31:30]);
   endfunction

   // Random word, W and B bits
   function automatic logic [0:devAddrWidth-1] makeDevAddr(input logic a17,
                                                           input logic [pageIndexWidth-1:0] page);
      logic [31:0]             r;
      logic [0:devAddrWidth-1] addr;
      r = nextRandom();
      addr = r[31:14];
      addr[0] = a17;
      addr[1:6] = page;
      return addr;
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Read layout: flags 5 to 8, PPN 16 to 26; status fault 35, cause 34, page 28 to 33
   function automatic logic [0:wordWidth-1] expectedRead(input logic [regAddrWidth-1:0] addr);
      logic [0:wordWidth-1] word;
      word = '0;
      if (addr == statusRegAddr)
      begin
         word[35] = statusFault;
         word[34] = statusCause;
         word[28:33] = statusPage;
      end
      else
      begin
         word[5:8] = modelFlags[addr[5:0]];
         word[16:26] = modelPpn[addr[5:0]];
      end
      return word;
   endfunction

   // Write layout: flags 18 to 21, PPN 25 to 35
   function automatic void modelWrite(input logic [regAddrWidth-1:0] addr,
                                      input logic [0:wordWidth-1] data);
      if (addr == statusRegAddr)
      begin
         statusFault = 1'b0;
         statusCause = 1'b0;
         statusPage  = '0;
      end
      else
      begin
         modelFlags[addr[5:0]] = data[18:21];
         modelPpn[addr[5:0]]   = data[25:35];
      end
   endfunction

   function automatic void expectDevice(input logic [0:devAddrWidth-1] addr);
      logic [pageIndexWidth-1:0] page;
      logic                      fail;
      page = addr[1:6];
      // Over-range or entry not valid
      fail = addr[0] || !modelFlags[page][3];
      expPageFail = fail;
      expMemAddr  = {modelPpn[page], addr[7:15]};
      expMemFlags = {modelFlags[page][0:2], addr[16], addr[17]};
      // Sticky, first fault kept
      if (fail && !statusFault)
      begin
         statusFault = 1'b1;
         statusCause = addr[0];
         statusPage  = page;
      end
   endfunction

   ////////////////////////////////////////
   // Handshake drivers
   ////////////////////////////////////////

   task automatic waitAck(input logic isDev, input logic level);
      int   cycles;
      logic seen;
      cycles = 0;
      seen = 1'b0;
      while (!seen && (cycles < ackTimeout))
      begin
         @(posedge clk);
         #1;
         cycles++;
         seen = ((isDev ? devAck : cpuAck) == level);
      end
      if (!seen)
      begin
         $display("Timeout: %s did not go to %0d within %0d cycles",
                  isDev ? "devAck" : "cpuAck", level, ackTimeout);
         $display("Test failures found");
         $finish;
      end
   endtask

   task automatic cpuAccess(input logic write, input logic [regAddrWidth-1:0] addr,
                            input logic [0:wordWidth-1] data);
      @(posedge clk);
      #1;
      cpuWrite = write;
      cpuAddr  = addr;
      cpuWData = data;
      cpuReq   = 1'b1;
      cpuIssued++;
      waitAck(1'b0, 1'b1);
      // Ready before the checker samples this cycle
      if (write)
      begin
         cpuExpect = 1'b0;
         modelWrite(addr, data);
      end
      else
      begin
         cpuExpect = 1'b1;
         expCpuRData = expectedRead(addr);
      end
      // Hold req a while for back-pressure
      repeat (1 + fewCycles()) @(posedge clk);
      #1;
      cpuReq = 1'b0;
      waitAck(1'b0, 1'b0);
   endtask

   task automatic devAccess(input logic [0:devAddrWidth-1] addr);
      @(posedge clk);
      #1;
      devAddr = addr;
      devReq  = 1'b1;
      devIssued++;
      waitAck(1'b1, 1'b1);
      expectDevice(addr);
      repeat (1 + fewCycles()) @(posedge clk);
      #1;
      devReq = 1'b0;
      waitAck(1'b1, 1'b0);
   endtask

   // Bit 21 of the write layout is VLD
   task automatic writeEntry(input logic [pageIndexWidth-1:0] page, input logic valid);
      logic [0:wordWidth-1] data;
      data = randomWord();
      data[21] = valid;
      cpuAccess(1'b1, {1'b0, page}, data);
   endtask

   task automatic finishTest();
      @(posedge clk);
      #1;
      testDone = 1'b1;
      @(posedge clk);
      #1;
      testDone = 1'b0;
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic entryRoundTrip();
      logic [regAddrWidth-1:0] addr;
      // Fill the whole table first
      for (int p = 0; p < numPages; p++)
      begin
         cpuAccess(1'b1, 7'(p), randomWord());
      end
      repeat (40)
      begin
         addr = {1'b0, randomPage()};
         cpuAccess(1'b1, addr, randomWord());
         cpuAccess(1'b0, addr, '0);
      end
      for (int p = 0; p < numPages; p++)
      begin
         cpuAccess(1'b0, 7'(p), '0);
      end
   endtask

   task automatic validTranslation();
      logic [pageIndexWidth-1:0] page;
      repeat (40)
      begin
         page = randomPage();
         if (!modelFlags[page][3])
         begin
            writeEntry(page, 1'b1);
         end
         devAccess(makeDevAddr(1'b0, page));
      end
   endtask

   task automatic invalidPage();
      logic [pageIndexWidth-1:0] first;
      logic [pageIndexWidth-1:0] second;
      repeat (8)
      begin
         cpuAccess(1'b1, statusRegAddr, randomWord());
         first = randomPage();
         second = randomPage();
         writeEntry(first, 1'b0);
         writeEntry(second, 1'b0);
         devAccess(makeDevAddr(1'b0, first));
         // Second fault must not replace the first
         devAccess(makeDevAddr(1'b0, second));
         cpuAccess(1'b0, statusRegAddr, '0);
      end
   endtask

   task automatic overRange();
      repeat (8)
      begin
         cpuAccess(1'b1, statusRegAddr, randomWord());
         devAccess(makeDevAddr(1'b1, randomPage()));
         devAccess(makeDevAddr(1'b1, randomPage()));
         cpuAccess(1'b0, statusRegAddr, '0);
      end
   endtask

   task automatic statusClear();
      logic [pageIndexWidth-1:0] page;
      repeat (6)
      begin
         devAccess(makeDevAddr(1'b1, randomPage()));
         cpuAccess(1'b1, statusRegAddr, randomWord());
         cpuAccess(1'b0, statusRegAddr, '0);
         // Fault again after the clear
         page = randomPage();
         writeEntry(page, 1'b0);
         devAccess(makeDevAddr(1'b0, page));
         cpuAccess(1'b0, statusRegAddr, '0);
      end
   endtask

   task automatic concurrentTraffic();
      fork
         repeat (60)
         begin
            repeat (fewCycles()) @(posedge clk);
            cpuAccess(chance(50), chance(15) ? statusRegAddr : {1'b0, randomPage()},
                      randomWord());
         end
         repeat (60)
         begin
            repeat (fewCycles()) @(posedge clk);
            devAccess(makeDevAddr(chance(10), randomPage()));
         end
      join
   endtask

   ////////////////////////////////////////
   // Run
   ////////////////////////////////////////

   initial
   begin
      seed        = 32'hf19e;
      rst         = 1'b1;
      cpuReq      = 1'b0;
      cpuWrite    = 1'b0;
      cpuAddr     = '0;
      cpuWData    = '0;
      devReq      = 1'b0;
      devAddr     = '0;
      testId      = 0;
      testDone    = 1'b0;
      runDone     = 1'b0;
      cpuExpect   = 1'b0;
      expCpuRData = '0;
      expMemAddr  = '0;
      expMemFlags = '0;
      expPageFail = 1'b0;
      cpuIssued   = 0;
      devIssued   = 0;
      statusFault = 1'b0;
      statusCause = 1'b0;
      statusPage  = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      testId = 1;
      entryRoundTrip();
      finishTest();
      testId = 2;
      validTranslation();
      finishTest();
      testId = 3;
      invalidPage();
      finishTest();
      testId = 4;
      overRange();
      finishTest();
      testId = 5;
      statusClear();
      finishTest();
      testId = 6;
      concurrentTraffic();
      finishTest();
      // Checker prints the counts at this falling edge
      @(posedge clk);
      #1;
      runDone = 1'b1;
      @(posedge clk);
      #1;
      runDone = 1'b0;
      if (failCount == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* project.f */
logic/ioBridgePkg.sv
logic/bridgeControl.sv
logic/pageMap.sv
logic/addressTranslator.sv
logic/cpuRegisterPort.sv
logic/ioBridge.sv
verif/ioBridgeChecker.sv
verif/ioBridgeTb.sv

/* Makefile */
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := ioBridgeTb
FILELIST  := project.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed!
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

# The log decides the result
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
